//--- Bender.yml
package:
  name: compute_tile_mem

sources:
  - logic/tile_pkg.sv
  - logic/dbg_pkg.sv
  - logic/dbg_ctrl.sv
  - logic/wb2axi.sv
  - logic/axi_ram.sv
  - logic/compute_tile_mem.sv
  - target: test
    files:
      - verification/tb_compute_tile_mem.sv

//--- compute_tile_mem.f
logic/tile_pkg.sv
logic/dbg_pkg.sv
logic/dbg_ctrl.sv
logic/wb2axi.sv
logic/axi_ram.sv
logic/compute_tile_mem.sv
verification/tb_compute_tile_mem.sv

//--- logic/axi_ram.sv
`timescale 1ns/1ps

module axi_ram (
   input  logic                              sys_clk,
   input  logic                              rst_n_i,
   input  logic [tile_pkg::AXI_ID_WIDTH-1:0] awid_i,
   input  logic [tile_pkg::ADDR_WIDTH-1:0]   awaddr_i,
   input  logic                              awvalid_i,
   output logic                              awready_o,
   input  logic [tile_pkg::DATA_WIDTH-1:0]   wdata_i,
   input  logic [tile_pkg::STRB_WIDTH-1:0]   wstrb_i,
   input  logic                              wvalid_i,
   output logic                              wready_o,
   output logic [tile_pkg::AXI_ID_WIDTH-1:0] bid_o,
   output logic [1:0]                        bresp_o,
   output logic                              bvalid_o,
   input  logic                              bready_i,
   input  logic [tile_pkg::AXI_ID_WIDTH-1:0] arid_i,
   input  logic [tile_pkg::ADDR_WIDTH-1:0]   araddr_i,
   input  logic                              arvalid_i,
   output logic                              arready_o,
   output logic [tile_pkg::AXI_ID_WIDTH-1:0] rid_o,
   output logic [tile_pkg::DATA_WIDTH-1:0]   rdata_o,
   output logic [1:0]                        rresp_o,
   output logic                              rvalid_o,
   input  logic                              rready_i
);

   logic [tile_pkg::DATA_WIDTH-1:0] mem [tile_pkg::MEM_WORDS];
   logic wr_fire, rd_fire, wr_in_range, rd_in_range;
   logic bvalid_q, rvalid_q;

   // AW and W are taken together, one response in flight per channel
   assign awready_o = awvalid_i && wvalid_i && !bvalid_q;
   assign wready_o  = awready_o;
   assign arready_o = !rvalid_q;
   assign wr_fire   = awready_o;
   assign rd_fire   = arvalid_i && arready_o;

   assign wr_in_range = awaddr_i < tile_pkg::MEM_WORDS;
   assign rd_in_range = araddr_i < tile_pkg::MEM_WORDS;

   always_ff @(posedge sys_clk) begin
      if (wr_fire && wr_in_range) begin
         for (int b = 0; b < tile_pkg::STRB_WIDTH; b++) begin
            if (wstrb_i[b]) begin
               mem[awaddr_i[tile_pkg::MEM_IDX_WIDTH-1:0]][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (wr_fire) begin
         bid_o   <= awid_i;
         bresp_o <= wr_in_range ? tile_pkg::RESP_OKAY : tile_pkg::RESP_SLVERR;
      end
      if (rd_fire) begin
         rid_o   <= arid_i;
         rresp_o <= rd_in_range ? tile_pkg::RESP_OKAY : tile_pkg::RESP_SLVERR;
         // Out of range reads as zero
         rdata_o <= rd_in_range ? mem[araddr_i[tile_pkg::MEM_IDX_WIDTH-1:0]] : '0;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!rst_n_i) begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr_fire) begin
            bvalid_q <= 1'b1;
         end else if (bready_i) begin
            bvalid_q <= 1'b0;
         end
         if (rd_fire) begin
            rvalid_q <= 1'b1;
         end else if (rready_i) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   assign bvalid_o = bvalid_q;
   assign rvalid_o = rvalid_q;

   a_b_held: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
      bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));
   a_r_held: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
      rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule

//--- logic/compute_tile_mem.sv
`timescale 1ns/1ps

module compute_tile_mem (
   input  logic                           sys_clk,
   input  logic                           rst_n_i,
   input  logic [dbg_pkg::HOST_WIDTH-1:0] host_in_data_i,
   input  logic                           host_in_valid_i,
   output logic                           host_in_ready_o,
   output logic [dbg_pkg::HOST_WIDTH-1:0] host_out_data_o,
   output logic                           host_out_valid_o,
   input  logic                           host_out_ready_i,
   output logic                           sys_rst_o,
   output logic                           cpu_rst_o
);

   logic logic_rst;

   // Debug controller to bridge
   logic wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
   logic [tile_pkg::ADDR_WIDTH-1:0] wb_adr;
   logic [tile_pkg::DATA_WIDTH-1:0] wb_dat_m2s, wb_dat_s2m;

   // Bridge to memory
   logic [tile_pkg::AXI_ID_WIDTH-1:0] awid, bid, arid, rid;
   logic [tile_pkg::ADDR_WIDTH-1:0]   awaddr, araddr;
   logic [tile_pkg::DATA_WIDTH-1:0]   wdata, rdata;
   logic [tile_pkg::STRB_WIDTH-1:0]   wstrb;
   logic [1:0]                        bresp, rresp;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;

   dbg_ctrl u_dbg_ctrl (
      .sys_clk          (sys_clk),
      .rst_n_i          (rst_n_i),
      .host_in_data_i   (host_in_data_i),
      .host_in_valid_i  (host_in_valid_i),
      .host_in_ready_o  (host_in_ready_o),
      .host_out_data_o  (host_out_data_o),
      .host_out_valid_o (host_out_valid_o),
      .host_out_ready_i (host_out_ready_i),
      .wb_cyc_o         (wb_cyc),
      .wb_stb_o         (wb_stb),
      .wb_we_o          (wb_we),
      .wb_adr_o         (wb_adr),
      .wb_dat_o         (wb_dat_m2s),
      .wb_dat_i         (wb_dat_s2m),
      .wb_ack_i         (wb_ack),
      .wb_err_i         (wb_err),
      .sys_rst_o        (sys_rst_o),
      .cpu_rst_o        (cpu_rst_o),
      .logic_rst_o      (logic_rst)
   );

   // Wishbone to AXI for the memory stand-in
   wb2axi u_wb2axi (
      .sys_clk   (sys_clk),
      .rst_n_i   (!logic_rst),
      .wb_cyc_i  (wb_cyc),
      .wb_stb_i  (wb_stb),
      .wb_we_i   (wb_we),
      .wb_adr_i  (wb_adr),
      .wb_dat_i  (wb_dat_m2s),
      .wb_dat_o  (wb_dat_s2m),
      .wb_ack_o  (wb_ack),
      .wb_err_o  (wb_err),
      .awid_o    (awid),
      .awaddr_o  (awaddr),
      .awvalid_o (awvalid),
      .awready_i (awready),
      .wdata_o   (wdata),
      .wstrb_o   (wstrb),
      .wvalid_o  (wvalid),
      .wready_i  (wready),
      .bid_i     (bid),
      .bresp_i   (bresp),
      .bvalid_i  (bvalid),
      .bready_o  (bready),
      .arid_o    (arid),
      .araddr_o  (araddr),
      .arvalid_o (arvalid),
      .arready_i (arready),
      .rid_i     (rid),
      .rdata_i   (rdata),
      .rresp_i   (rresp),
      .rvalid_i  (rvalid),
      .rready_o  (rready)
   );

   axi_ram u_axi_ram (
      .sys_clk   (sys_clk),
      .rst_n_i   (!logic_rst),
      .awid_i    (awid),
      .awaddr_i  (awaddr),
      .awvalid_i (awvalid),
      .awready_o (awready),
      .wdata_i   (wdata),
      .wstrb_i   (wstrb),
      .wvalid_i  (wvalid),
      .wready_o  (wready),
      .bid_o     (bid),
      .bresp_o   (bresp),
      .bvalid_o  (bvalid),
      .bready_i  (bready),
      .arid_i    (arid),
      .araddr_i  (araddr),
      .arvalid_i (arvalid),
      .arready_o (arready),
      .rid_o     (rid),
      .rdata_o   (rdata),
      .rresp_o   (rresp),
      .rvalid_o  (rvalid),
      .rready_i  (rready)
   );

endmodule

//--- logic/dbg_ctrl.sv
`timescale 1ns/1ps

module dbg_ctrl (
   input  logic                            sys_clk,
   input  logic                            rst_n_i,
   input  logic [dbg_pkg::HOST_WIDTH-1:0]  host_in_data_i,
   input  logic                            host_in_valid_i,
   output logic                            host_in_ready_o,
   output logic [dbg_pkg::HOST_WIDTH-1:0]  host_out_data_o,
   output logic                            host_out_valid_o,
   input  logic                            host_out_ready_i,
   output logic                            wb_cyc_o,
   output logic                            wb_stb_o,
   output logic                            wb_we_o,
   output logic [tile_pkg::ADDR_WIDTH-1:0] wb_adr_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] wb_dat_o,
   input  logic [tile_pkg::DATA_WIDTH-1:0] wb_dat_i,
   input  logic                            wb_ack_i,
   input  logic                            wb_err_i,
   output logic                            sys_rst_o,
   output logic                            cpu_rst_o,
   output logic                            logic_rst_o
);

   dbg_pkg::dbg_state_e state_q, state_d;
   dbg_pkg::dbg_op_e    op;
   logic in_fire, out_fire, bus_done;
   logic in_ready_q, sys_rst_q, cpu_rst_q;
   logic write_q, err_q;
   logic [tile_pkg::ADDR_WIDTH-1:0] adr_q;
   logic [tile_pkg::DATA_WIDTH-1:0] wdata_q, rdata_q;

   assign op       = dbg_pkg::dbg_op_e'(host_in_data_i[dbg_pkg::HOST_WIDTH-1 -: 4]);
   assign in_fire  = host_in_valid_i && in_ready_q;
   assign out_fire = host_out_valid_o && host_out_ready_i;
   assign bus_done = wb_ack_i || wb_err_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         dbg_pkg::IDLE: begin
            if (in_fire && (op == dbg_pkg::OP_WRITE || op == dbg_pkg::OP_READ)) begin
               state_d = dbg_pkg::GET_ADDR;
            end
         end
         dbg_pkg::GET_ADDR: begin
            if (in_fire) begin
               state_d = write_q ? dbg_pkg::GET_HI : dbg_pkg::BUS;
            end
         end
         dbg_pkg::GET_HI: if (in_fire) state_d = dbg_pkg::GET_LO;
         dbg_pkg::GET_LO: if (in_fire) state_d = dbg_pkg::BUS;
         dbg_pkg::BUS:    if (bus_done) state_d = dbg_pkg::SEND_STAT;
         dbg_pkg::SEND_STAT: begin
            if (out_fire) begin
               state_d = write_q ? dbg_pkg::IDLE : dbg_pkg::SEND_HI;
            end
         end
         dbg_pkg::SEND_HI: if (out_fire) state_d = dbg_pkg::SEND_LO;
         default:          if (out_fire) state_d = dbg_pkg::IDLE;
      endcase
   end

   always_ff @(posedge sys_clk) begin
      if (!rst_n_i) begin
         state_q    <= dbg_pkg::IDLE;
         in_ready_q <= 1'b0;
         sys_rst_q  <= 1'b0;
         cpu_rst_q  <= 1'b0;
      end else begin
         state_q    <= state_d;
         // Intake stays closed until the response has drained
         in_ready_q <= state_d inside {dbg_pkg::IDLE, dbg_pkg::GET_ADDR,
                                       dbg_pkg::GET_HI, dbg_pkg::GET_LO};
         if (state_q == dbg_pkg::IDLE && in_fire && op == dbg_pkg::OP_RESET) begin
            sys_rst_q <= host_in_data_i[0];
            cpu_rst_q <= host_in_data_i[1];
         end
      end
   end

   // Command fields and bus result
   always_ff @(posedge sys_clk) begin
      if (in_fire) begin
         case (state_q)
            dbg_pkg::IDLE:     write_q <= (op == dbg_pkg::OP_WRITE);
            dbg_pkg::GET_ADDR: adr_q <= host_in_data_i;
            dbg_pkg::GET_HI:   wdata_q[tile_pkg::DATA_WIDTH-1 -: 16] <= host_in_data_i;
            dbg_pkg::GET_LO:   wdata_q[15:0] <= host_in_data_i;
            default: ;
         endcase
      end
      if (state_q == dbg_pkg::BUS && bus_done) begin
         err_q   <= wb_err_i;
         rdata_q <= wb_dat_i;
      end
   end

   always_comb begin
      case (state_q)
         dbg_pkg::SEND_HI: host_out_data_o = rdata_q[tile_pkg::DATA_WIDTH-1 -: 16];
         dbg_pkg::SEND_LO: host_out_data_o = rdata_q[15:0];
         default:          host_out_data_o = err_q ? dbg_pkg::STAT_ERR : dbg_pkg::STAT_OK;
      endcase
   end

   assign host_out_valid_o = state_q inside {dbg_pkg::SEND_STAT, dbg_pkg::SEND_HI,
                                             dbg_pkg::SEND_LO};
   assign host_in_ready_o  = in_ready_q;

   assign wb_cyc_o = (state_q == dbg_pkg::BUS);
   assign wb_stb_o = (state_q == dbg_pkg::BUS);
   assign wb_we_o  = write_q;
   assign wb_adr_o = adr_q;
   assign wb_dat_o = wdata_q;

   assign sys_rst_o   = sys_rst_q;
   assign cpu_rst_o   = cpu_rst_q;
   // Bus side reset, only the external reset for now
   assign logic_rst_o = !rst_n_i;

   a_out_stable: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
      host_out_valid_o && !host_out_ready_i |=> host_out_valid_o && $stable(host_out_data_o));

endmodule

//--- logic/dbg_pkg.sv
package dbg_pkg;

   // Host link word
   localparam int unsigned HOST_WIDTH = 16;

   // Top nibble of a command word
   typedef enum logic [3:0] {
      OP_NOP   = 4'h0,
      OP_WRITE = 4'h1,
      OP_READ  = 4'h2,
      OP_RESET = 4'h3
   } dbg_op_e;

   typedef enum logic [2:0] {
      IDLE,
      GET_ADDR,
      GET_HI,
      GET_LO,
      BUS,
      SEND_STAT,
      SEND_HI,
      SEND_LO
   } dbg_state_e;

   // Status word sent ahead of any read data
   localparam logic [HOST_WIDTH-1:0] STAT_OK  = 16'h0000;
   localparam logic [HOST_WIDTH-1:0] STAT_ERR = 16'h0001;

endpackage

//--- logic/tile_pkg.sv
package tile_pkg;

   // Word addressed memory path
   localparam int unsigned ADDR_WIDTH    = 16;
   localparam int unsigned DATA_WIDTH    = 32;
   localparam int unsigned STRB_WIDTH    = DATA_WIDTH / 8;

   // Implemented words, anything at or above is out of range
   localparam int unsigned MEM_WORDS     = 1024;
   localparam int unsigned MEM_IDX_WIDTH = $clog2(MEM_WORDS);

   // Single fixed AXI ID
   localparam int unsigned AXI_ID_WIDTH  = 4;
   localparam logic [AXI_ID_WIDTH-1:0] AXI_ID = '0;

   // AXI response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- logic/wb2axi.sv
`timescale 1ns/1ps

module wb2axi (
   input  logic                              sys_clk,
   input  logic                              rst_n_i,
   input  logic                              wb_cyc_i,
   input  logic                              wb_stb_i,
   input  logic                              wb_we_i,
   input  logic [tile_pkg::ADDR_WIDTH-1:0]   wb_adr_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0]   wb_dat_i,
   output logic [tile_pkg::DATA_WIDTH-1:0]   wb_dat_o,
   output logic                              wb_ack_o,
   output logic                              wb_err_o,
   output logic [tile_pkg::AXI_ID_WIDTH-1:0] awid_o,
   output logic [tile_pkg::ADDR_WIDTH-1:0]   awaddr_o,
   output logic                              awvalid_o,
   input  logic                              awready_i,
   output logic [tile_pkg::DATA_WIDTH-1:0]   wdata_o,
   output logic [tile_pkg::STRB_WIDTH-1:0]   wstrb_o,
   output logic                              wvalid_o,
   input  logic                              wready_i,
   input  logic [tile_pkg::AXI_ID_WIDTH-1:0] bid_i,
   input  logic [1:0]                        bresp_i,
   input  logic                              bvalid_i,
   output logic                              bready_o,
   output logic [tile_pkg::AXI_ID_WIDTH-1:0] arid_o,
   output logic [tile_pkg::ADDR_WIDTH-1:0]   araddr_o,
   output logic                              arvalid_o,
   input  logic                              arready_i,
   input  logic [tile_pkg::AXI_ID_WIDTH-1:0] rid_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0]   rdata_i,
   input  logic [1:0]                        rresp_i,
   input  logic                              rvalid_i,
   output logic                              rready_o
);

   typedef enum logic [2:0] {
      BR_IDLE,
      BR_WREQ,
      BR_RREQ,
      BR_WAITB,
      BR_WAITR,
      BR_DONE
   } br_state_e;

   br_state_e state_q;
   logic awvalid_q, wvalid_q, arvalid_q;
   logic start, err_q;
   logic [tile_pkg::ADDR_WIDTH-1:0] addr_q;
   logic [tile_pkg::DATA_WIDTH-1:0] wdata_q, rdata_q;

   // Only sampled in idle, so the cycle just acked is not taken twice
   assign start = (state_q == BR_IDLE) && wb_cyc_i && wb_stb_i;

   always_ff @(posedge sys_clk) begin
      if (!rst_n_i) begin
         state_q   <= BR_IDLE;
         awvalid_q <= 1'b0;
         wvalid_q  <= 1'b0;
         arvalid_q <= 1'b0;
      end else begin
         case (state_q)
            BR_IDLE: begin
               if (start && wb_we_i) begin
                  awvalid_q <= 1'b1;
                  wvalid_q  <= 1'b1;
                  state_q   <= BR_WREQ;
               end else if (start) begin
                  arvalid_q <= 1'b1;
                  state_q   <= BR_RREQ;
               end
            end
            BR_WREQ: begin
               if (awready_i) awvalid_q <= 1'b0;
               if (wready_i) wvalid_q <= 1'b0;
               // AW and W may be taken in different cycles
               if ((!awvalid_q || awready_i) && (!wvalid_q || wready_i)) begin
                  state_q <= BR_WAITB;
               end
            end
            BR_RREQ: begin
               if (arready_i) begin
                  arvalid_q <= 1'b0;
                  state_q   <= BR_WAITR;
               end
            end
            BR_WAITB: if (bvalid_i) state_q <= BR_DONE;
            BR_WAITR: if (rvalid_i) state_q <= BR_DONE;
            default:  state_q <= BR_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (start) begin
         addr_q  <= wb_adr_i;
         wdata_q <= wb_dat_i;
      end
      if (state_q == BR_WAITB && bvalid_i) begin
         err_q <= (bresp_i != tile_pkg::RESP_OKAY) || (bid_i != tile_pkg::AXI_ID);
      end
      if (state_q == BR_WAITR && rvalid_i) begin
         err_q   <= (rresp_i != tile_pkg::RESP_OKAY) || (rid_i != tile_pkg::AXI_ID);
         rdata_q <= rdata_i;
      end
   end

   // One clock of ack or err per cycle
   assign wb_ack_o = (state_q == BR_DONE) && !err_q;
   assign wb_err_o = (state_q == BR_DONE) && err_q;
   assign wb_dat_o = rdata_q;

   assign awid_o    = tile_pkg::AXI_ID;
   assign awaddr_o  = addr_q;
   assign awvalid_o = awvalid_q;
   assign wdata_o   = wdata_q;
   assign wstrb_o   = '1;
   assign wvalid_o  = wvalid_q;
   assign bready_o  = 1'b1;
   assign arid_o    = tile_pkg::AXI_ID;
   assign araddr_o  = addr_q;
   assign arvalid_o = arvalid_q;
   assign rready_o  = 1'b1;

   a_one_outstanding: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
      (awvalid_o && awready_i) || (arvalid_o && arready_i)
      |=> (!awvalid_o && !arvalid_o) until_with (bvalid_i || rvalid_i));

endmodule

//--- verification/compute_tile_mem_vectors.txt
# name ncmd cmd0 cmd1 cmd2 cmd3 nresp resp0 resp1 resp2 rst
# words in hex, unused columns 0, rst is {cpu_rst, sys_rst} once the command is done
wr_first     4 1000 0010 dead beef 1 0000 0000 0000 0
rd_first     2 2000 0010 0000 0000 3 0000 dead beef 0
wr_top       4 1000 03ff 1234 5678 1 0000 0000 0000 0
rd_top       2 2000 03ff 0000 0000 3 0000 1234 5678 0
wr_zero      4 1000 0000 0000 0001 1 0000 0000 0000 0
rd_oor       2 2000 0400 0000 0000 3 0001 0000 0000 0
rd_oor_high  2 2000 ffff 0000 0000 3 0001 0000 0000 0
wr_oor       4 1000 0400 aaaa 5555 1 0001 0000 0000 0
rd_zero_kept 2 2000 0000 0000 0000 3 0000 0000 0001 0
wr_oor_high  4 1000 c3ff 1111 2222 1 0001 0000 0000 0
rd_top_kept  2 2000 03ff 0000 0000 3 0000 1234 5678 0
rst_sys      1 3001 0000 0000 0000 0 0000 0000 0000 1
rst_cpu      1 3002 0000 0000 0000 0 0000 0000 0000 2
rst_both     1 3003 0000 0000 0000 0 0000 0000 0000 3
rd_in_rst    2 2000 0010 0000 0000 3 0000 dead beef 3
rst_clear    1 3000 0000 0000 0000 0 0000 0000 0000 0
rd_kept      2 2000 0010 0000 0000 3 0000 dead beef 0
nop          1 0000 0000 0000 0000 0 0000 0000 0000 0
wr_over      4 1000 0010 cafe f00d 1 0000 0000 0000 0
rd_over      2 2000 0010 0000 0000 3 0000 cafe f00d 0

//--- verification/tb_compute_tile_mem.sv
`timescale 1ns/1ps

module tb_compute_tile_mem;

   localparam int CLK_PERIOD     = 40;
   localparam int RESET_CYCLES   = 16;
   localparam int CYCLES_PER_VEC = 200;
   localparam int MAX_VEC        = 32;

   logic                           sys_clk;
   logic                           rst_n_i;
   logic [dbg_pkg::HOST_WIDTH-1:0] host_in_data_i;
   logic                           host_in_valid_i;
   logic                           host_in_ready_o;
   logic [dbg_pkg::HOST_WIDTH-1:0] host_out_data_o;
   logic                           host_out_valid_o;
   logic                           host_out_ready_i;
   logic                           sys_rst_o;
   logic                           cpu_rst_o;

   // One entry per vectors line
   string       vec_name  [MAX_VEC];
   int          vec_ncmd  [MAX_VEC];
   logic [15:0] vec_cmd   [MAX_VEC][4];
   int          vec_nresp [MAX_VEC];
   logic [15:0] vec_resp  [MAX_VEC][3];
   logic [1:0]  vec_rst   [MAX_VEC];
   int          vec_count;
   logic        vectors_loaded;
   int          err_count;
   int          check_count;
   integer      seed;

   compute_tile_mem dut0 (
      .sys_clk          (sys_clk),
      .rst_n_i          (rst_n_i),
      .host_in_data_i   (host_in_data_i),
      .host_in_valid_i  (host_in_valid_i),
      .host_in_ready_o  (host_in_ready_o),
      .host_out_data_o  (host_out_data_o),
      .host_out_valid_o (host_out_valid_o),
      .host_out_ready_i (host_out_ready_i),
      .sys_rst_o        (sys_rst_o),
      .cpu_rst_o        (cpu_rst_o)
   );

   initial begin
      sys_clk = 1'b0;
      forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
   end

   task automatic compare_word(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
      check_count++;
      assert (act === exp) else begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         err_count++;
      end
   endtask

   task automatic load_vectors();
      int          fd;
      int          fields;
      int          ncmd;
      int          nresp;
      string       line;
      string       name;
      logic [15:0] c0, c1, c2, c3, r0, r1, r2;
      logic [1:0]  rst;
      fd = $fopen("verification/compute_tile_mem_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vectors file");
         err_count++;
         return;
      end
      while (!$feof(fd) && vec_count < MAX_VEC) begin
         line = "";
         void'($fgets(line, fd));
         // Skip blank and column description lines
         if (line.len() < 2 || line.getc(0) == "#") continue;
         fields = $sscanf(line, "%s %d %h %h %h %h %d %h %h %h %h",
                          name, ncmd, c0, c1, c2, c3, nresp, r0, r1, r2, rst);
         if (fields != 11 || ncmd > 4 || nresp > 3) begin
            $display("Malformed line in the vectors file: %s", line);
            err_count++;
            continue;
         end
         vec_name[vec_count]  = name;
         vec_ncmd[vec_count]  = ncmd;
         vec_cmd[vec_count]   = '{c0, c1, c2, c3};
         vec_nresp[vec_count] = nresp;
         vec_resp[vec_count]  = '{r0, r1, r2};
         vec_rst[vec_count]   = rst;
         vec_count++;
      end
      $fclose(fd);
   endtask

   // Word moves on the rising edge after valid and ready meet
   task automatic send_word(input logic [15:0] word);
      @(posedge sys_clk);
      host_in_valid_i <= 1'b1;
      host_in_data_i  <= word;
      do @(negedge sys_clk); while (!host_in_ready_o);
      @(posedge sys_clk);
      host_in_valid_i <= 1'b0;
   endtask

   task automatic receive_word(input string name, input logic [15:0] exp);
      logic        held;
      logic        done;
      logic [15:0] held_data;
      logic [15:0] got;
      held = 1'b0;
      done = 1'b0;
      while (!done) begin
         @(posedge sys_clk);
         host_out_ready_i <= ($random(seed) & 3) != 0;
         @(negedge sys_clk);
         // No command intake while a response is pending
         compare_word({name, " intake closed"}, 16'h0, {15'h0, host_in_ready_o});
         if (host_out_valid_o) begin
            if (held) compare_word({name, " held"}, held_data, host_out_data_o);
            if (host_out_ready_i) begin
               got  = host_out_data_o;
               done = 1'b1;
            end else begin
               held      = 1'b1;
               held_data = host_out_data_o;
            end
         end else if (held) begin
            $display("%s: response valid dropped before the word was taken", name);
            err_count++;
            held = 1'b0;
         end
      end
      compare_word(name, exp, got);
   endtask

   task automatic run_vector(input int v);
      for (int i = 0; i < vec_ncmd[v]; i++) begin
         send_word(vec_cmd[v][i]);
      end
      for (int i = 0; i < vec_nresp[v]; i++) begin
         receive_word($sformatf("%s word %0d", vec_name[v], i), vec_resp[v][i]);
      end
      // Host out stalled so a surplus response word stays visible
      @(posedge sys_clk);
      host_out_ready_i <= 1'b0;
      @(negedge sys_clk);
      check_count++;
      assert (!host_out_valid_o) else begin
         $display("%s: response word left over after the expected ones", vec_name[v]);
         err_count++;
      end
      // Intake reopens once the response has drained
      while (!host_in_ready_o) @(negedge sys_clk);
      compare_word({vec_name[v], " reset requests"}, {14'h0, vec_rst[v]},
                   {14'h0, cpu_rst_o, sys_rst_o});
   endtask

   initial begin : watchdog
      wait (vectors_loaded);
      #((RESET_CYCLES + (vec_count + 1) * CYCLES_PER_VEC) * CLK_PERIOD);
      $display("Timeout: %0d vectors did not complete in the allowed time", vec_count);
      err_count++;
      $display("Checks: %0d, errors: %0d", check_count, err_count);
      $display("Errors found");
      $finish;
   end

   initial begin
      seed             = 32'hf52aa531;
      err_count        = 0;
      check_count      = 0;
      vec_count        = 0;
      vectors_loaded   = 1'b0;
      rst_n_i          = 1'b0;
      host_in_data_i   = '0;
      host_in_valid_i  = 1'b0;
      host_out_ready_i = 1'b0;
      load_vectors();
      vectors_loaded = 1'b1;
      if (vec_count == 0) begin
         $display("No vectors were loaded");
         err_count++;
      end
      repeat (RESET_CYCLES) @(posedge sys_clk);
      rst_n_i <= 1'b1;
      @(negedge sys_clk);
      compare_word("after_reset out valid", 16'h0, {15'h0, host_out_valid_o});
      compare_word("after_reset reset requests", 16'h0, {14'h0, cpu_rst_o, sys_rst_o});
      for (int v = 0; v < vec_count; v++) begin
         run_vector(v);
      end
      $display("Checks: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule
